// ==== rtl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // Widths
    localparam int REG_WIDTH  = 32;
    localparam int INST_WIDTH = 32;
    localparam int SEL_WIDTH  = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_WIDTH  = 16;
    localparam int OFS_WIDTH  = 26;

    // Register select fields in the instruction word
    localparam int SEL1_LSB = 21;
    localparam int SEL2_LSB = 16;

    // Banks
    localparam int NUM_BANKS = 2;
    localparam int BANK_INT  = 0;
    localparam int BANK_FP   = 1;

    typedef logic [REG_WIDTH-1:0]  reg_word_t;
    typedef logic [INST_WIDTH-1:0] inst_word_t;
    typedef logic [SEL_WIDTH-1:0]  reg_idx_t;

    // One bank's writeback port
    typedef struct packed {
        logic      write;
        reg_idx_t  sel;
        reg_word_t data;
    } bank_wr_t;

    // One bank's read selects
    typedef struct packed {
        reg_idx_t sel1;
        reg_idx_t sel2;
    } bank_rd_t;

    typedef struct packed {
        reg_word_t data1;
        reg_word_t data2;
        logic      err;
    } bank_out_t;

    // Control from the main decoder
    typedef struct packed {
        logic       xtend_sel;       // 1 zero-extends the immediate
        logic       fp_inst;
        logic [1:0] fp_int_cvt_reg;  // bit 0 marks FCVTI/FMOVI
        logic       mem_read;
        logic       mem_write;
        logic       fp_int_bypass1;
        logic       fp_int_bypass2;
    } dec_ctrl_t;

    typedef struct packed {
        reg_word_t reg1;
        reg_word_t reg2;
        reg_word_t fp_reg1;
        reg_word_t fp_reg2;
        reg_word_t imm;
        reg_word_t ofs;
        logic      decode_err;
    } dec_out_t;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file
    import decode_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  bank_rd_t  rd,
    input  bank_wr_t  wr,
    output bank_out_t rd_out
);

    reg_word_t regs [NUM_REGS];

    logic wr_zero;
    logic wr_en;

    ////////////////////
    // Write port
    ////////////////////

    // Register 0 is reserved, so a write there is flagged and dropped
    assign wr_zero = wr.write && (wr.sel == '0);
    assign wr_en   = wr.write && (wr.sel != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.sel] <= wr.data;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    always_comb begin
        rd_out.data1 = (rd.sel1 == '0) ? '0 : regs[rd.sel1];
        rd_out.data2 = (rd.sel2 == '0) ? '0 : regs[rd.sel2];
        rd_out.err   = wr_zero;
    end

    // Write select must be known whenever a write is requested
    a_wr_sel_known : assert property (
        @(posedge clk) disable iff (reset)
        wr.write |-> !$isunknown(wr.sel)
    ) else $error("reg_file write with unknown select");

endmodule

`default_nettype wire

// ==== rtl/bank_port_steer.sv ====
`default_nettype none

module bank_port_steer
    import decode_pkg::*;
(
    input  inst_word_t                 inst,
    input  bank_wr_t                   int_wr,
    input  bank_wr_t                   fp_wr,
    output bank_rd_t [NUM_BANKS-1:0]   rd_ports,
    output bank_wr_t [NUM_BANKS-1:0]   wr_ports,
    output logic     [NUM_BANKS-1:0]   fwd1,
    output logic     [NUM_BANKS-1:0]   fwd2
);

    reg_idx_t sel1;
    reg_idx_t sel2;

    // Both banks share the same select fields
    assign sel1 = inst[SEL1_LSB +: SEL_WIDTH];
    assign sel2 = inst[SEL2_LSB +: SEL_WIDTH];

    ////////////////////
    // Ports by bank
    ////////////////////

    always_comb begin
        wr_ports[BANK_INT] = int_wr;
        wr_ports[BANK_FP]  = fp_wr;
        for (int b = 0; b < NUM_BANKS; b++) begin
            rd_ports[b].sel1 = sel1;
            rd_ports[b].sel2 = sel2;
        end
    end

    ////////////////////
    // Same-bank forward
    ////////////////////

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            // Reg 0 never forwards since it always reads zero
            fwd1[b] = wr_ports[b].write && (wr_ports[b].sel != '0)
                      && (wr_ports[b].sel == sel1);
            fwd2[b] = wr_ports[b].write && (wr_ports[b].sel != '0)
                      && (wr_ports[b].sel == sel2);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_mux.sv ====
`default_nettype none

module operand_mux
    import decode_pkg::*;
(
    input  inst_word_t                 inst,
    input  dec_ctrl_t                  ctrl,
    input  bank_out_t [NUM_BANKS-1:0]  bank_outs,
    input  bank_wr_t  [NUM_BANKS-1:0]  wr_ports,
    input  logic      [NUM_BANKS-1:0]  fwd1,
    input  logic      [NUM_BANKS-1:0]  fwd2,
    output dec_out_t                   result
);

    reg_word_t [NUM_BANKS-1:0] fwd_op1;
    reg_word_t [NUM_BANKS-1:0] fwd_op2;

    reg_word_t int_op1;
    reg_word_t int_op2;
    logic      fp_mem;
    logic      fp_cvt;

    ////////////////////
    // Forwarding
    ////////////////////

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            fwd_op1[b] = fwd1[b] ? wr_ports[b].data : bank_outs[b].data1;
            fwd_op2[b] = fwd2[b] ? wr_ports[b].data : bank_outs[b].data2;
        end
    end

    // FP writeback feeds integer operands when no same-bank forward hits
    assign int_op1 = (!fwd1[BANK_INT] && ctrl.fp_int_bypass1) ?
                     wr_ports[BANK_FP].data : fwd_op1[BANK_INT];
    assign int_op2 = (!fwd2[BANK_INT] && ctrl.fp_int_bypass2) ?
                     wr_ports[BANK_FP].data : fwd_op2[BANK_INT];

    // FP load/store carries Fd in reg2
    assign fp_mem = ctrl.fp_inst && (ctrl.mem_read || ctrl.mem_write);
    // FCVTI and FMOVI take their source from the integer file
    assign fp_cvt = ctrl.fp_inst && ctrl.fp_int_cvt_reg[0];

    ////////////////////
    // Results
    ////////////////////

    always_comb begin
        result.reg1    = int_op1;
        result.reg2    = fp_mem ? fwd_op2[BANK_FP] : int_op2;
        result.fp_reg1 = fp_cvt ? int_op1 : fwd_op1[BANK_FP];
        result.fp_reg2 = fwd_op2[BANK_FP];

        // I-format immediate
        if (ctrl.xtend_sel) begin
            result.imm = {{(REG_WIDTH-IMM_WIDTH){1'b0}}, inst[IMM_WIDTH-1:0]};
        end else begin
            result.imm = {{(REG_WIDTH-IMM_WIDTH){inst[IMM_WIDTH-1]}},
                          inst[IMM_WIDTH-1:0]};
        end

        // J-format offset
        result.ofs = {{(REG_WIDTH-OFS_WIDTH){inst[OFS_WIDTH-1]}}, inst[OFS_WIDTH-1:0]};

        result.decode_err = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            result.decode_err = result.decode_err | bank_outs[b].err;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  inst_word_t inst,
    input  dec_ctrl_t  ctrl,
    input  bank_wr_t   int_wr,
    input  bank_wr_t   fp_wr,
    output dec_out_t   result
);

    bank_rd_t  [NUM_BANKS-1:0] rd_ports;
    bank_wr_t  [NUM_BANKS-1:0] wr_ports;
    bank_out_t [NUM_BANKS-1:0] bank_outs;
    logic      [NUM_BANKS-1:0] fwd1;
    logic      [NUM_BANKS-1:0] fwd2;

    ////////////////////
    // Port steering
    ////////////////////

    bank_port_steer u_steer (
        .inst     (inst),
        .int_wr   (int_wr),
        .fp_wr    (fp_wr),
        .rd_ports (rd_ports),
        .wr_ports (wr_ports),
        .fwd1     (fwd1),
        .fwd2     (fwd2)
    );

    ////////////////////
    // Register banks
    ////////////////////

    // Bank 0 is the integer file, bank 1 the FP file
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        reg_file u_rf (
            .clk    (clk),
            .reset  (reset),
            .rd     (rd_ports[b]),
            .wr     (wr_ports[b]),
            .rd_out (bank_outs[b])
        );
    end

    operand_mux u_mux (
        .inst      (inst),
        .ctrl      (ctrl),
        .bank_outs (bank_outs),
        .wr_ports  (wr_ports),
        .fwd1      (fwd1),
        .fwd2      (fwd2),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/decode_tb.sv ====
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          WAIT_LIMIT = 400;  // polls of 0.5 ns
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    typedef struct {
        string      name;
        inst_word_t inst;
        dec_ctrl_t  ctrl;
        bank_wr_t   int_wr;
        bank_wr_t   fp_wr;
        dec_out_t   exp;
    } step_t;

    logic        clk;
    logic        reset;
    inst_word_t  inst;
    dec_ctrl_t   ctrl;
    bank_wr_t    int_wr;
    bank_wr_t    fp_wr;
    dec_out_t    result;
    logic [31:0] lfsr;
    reg_word_t   int_model [NUM_REGS];
    reg_word_t   fp_model [NUM_REGS];
    step_t       steps [$];

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage dut (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .ctrl   (ctrl),
        .int_wr (int_wr),
        .fp_wr  (fp_wr),
        .result (result)
    );

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_word_t make_inst(reg_idx_t s1, reg_idx_t s2, logic [15:0] low);
        return {6'b0, s1, s2, low};
    endfunction

    function automatic reg_word_t read_reg(logic fp, reg_idx_t sel, bank_wr_t w);
        if (w.write && (sel != '0) && (w.sel == sel)) begin
            return w.data;
        end
        if (sel == '0) begin
            return '0;
        end
        return fp ? fp_model[sel] : int_model[sel];
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic dec_out_t expected_result(inst_word_t word, dec_ctrl_t c,
                                                 bank_wr_t iw, bank_wr_t fw);
        dec_out_t  e;
        reg_idx_t  s1;
        reg_idx_t  s2;
        reg_word_t i1;
        reg_word_t i2;
        reg_word_t f2;
        s1 = word[25:21];
        s2 = word[20:16];
        f2 = read_reg(1'b1, s2, fw);
        // Bypass of FP data only where the integer file does not forward
        i1 = read_reg(1'b0, s1, iw);
        if (c.fp_int_bypass1 && !(iw.write && s1 != '0 && iw.sel == s1)) begin
            i1 = fw.data;
        end
        i2 = read_reg(1'b0, s2, iw);
        if (c.fp_int_bypass2 && !(iw.write && s2 != '0 && iw.sel == s2)) begin
            i2 = fw.data;
        end
        e.reg1       = i1;
        e.reg2       = (c.fp_inst && (c.mem_read || c.mem_write)) ? f2 : i2;
        e.fp_reg1    = (c.fp_inst && c.fp_int_cvt_reg[0]) ? i1 : read_reg(1'b1, s1, fw);
        e.fp_reg2    = f2;
        e.imm        = c.xtend_sel ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
        e.ofs        = {{6{word[25]}}, word[25:0]};
        e.decode_err = (iw.write && iw.sel == '0) || (fw.write && fw.sel == '0);
        return e;
    endfunction

    task automatic add_step(string name, inst_word_t word, dec_ctrl_t c,
                            bank_wr_t iw, bank_wr_t fw);
        step_t s;
        s.name   = name;
        s.inst   = word;
        s.ctrl   = c;
        s.int_wr = iw;
        s.fp_wr  = fw;
        s.exp    = expected_result(word, c, iw, fw);
        steps.push_back(s);
        // Writes land at the edge that closes the step
        if (iw.write && iw.sel != '0) begin
            int_model[iw.sel] = iw.data;
        end
        if (fw.write && fw.sel != '0) begin
            fp_model[fw.sel] = fw.data;
        end
    endtask

    task automatic build_table();
        dec_ctrl_t  c;
        bank_wr_t   iw;
        bank_wr_t   fw;
        inst_word_t w;
        for (int r = 0; r < NUM_REGS; r++) begin
            add_step("reset_read", make_inst(reg_idx_t'(r), reg_idx_t'(r), 16'h0), '0, '0, '0);
        end
        for (int r = 1; r < NUM_REGS; r++) begin
            iw = '{1'b1, reg_idx_t'(r), rand_bits(32)};
            fw = '{1'b1, reg_idx_t'(NUM_REGS - r), rand_bits(32)};
            w  = make_inst(reg_idx_t'(r), reg_idx_t'(NUM_REGS - r), 16'h0);
            add_step("write_fwd", w, '0, iw, fw);
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            add_step("readback", make_inst(reg_idx_t'(r), reg_idx_t'(r + 5), 16'h0), '0, '0, '0);
        end
        // Register 0 is reserved
        add_step("int_wr_zero", make_inst('0, '0, 16'h0), '0, '{1'b1, 5'd0, rand_bits(32)}, '0);
        add_step("fp_wr_zero", make_inst('0, '0, 16'h0), '0, '0, '{1'b1, 5'd0, rand_bits(32)});
        add_step("zero_after", make_inst('0, '0, 16'h0), '0, '0, '0);
        for (int k = 0; k < 8; k++) begin
            c           = '0;
            c.xtend_sel = k[0];
            w           = rand_bits(32);
            w[15]       = k[1];
            w[25]       = k[2];
            add_step("imm_ofs", w, c, '0, '0);
        end
        // Cross-file steering
        c          = '0;
        c.fp_inst  = 1'b1;
        c.mem_read = 1'b1;
        add_step("fp_load", make_inst(5'd3, 5'd4, 16'h10), c, '0, '0);
        c.mem_read  = 1'b0;
        c.mem_write = 1'b1;
        add_step("fp_store", make_inst(5'd5, 5'd6, 16'h20), c, '0, '0);
        c                = '0;
        c.fp_inst        = 1'b1;
        c.fp_int_cvt_reg = 2'b01;
        add_step("fp_cvt", make_inst(5'd7, 5'd8, 16'h0), c, '0, '0);
        c                = '0;
        c.fp_int_bypass1 = 1'b1;
        c.fp_int_bypass2 = 1'b1;
        add_step("bypass", make_inst(5'd6, 5'd7, 16'h0), c, '0, '{1'b1, 5'd9, rand_bits(32)});
        iw = '{1'b1, 5'd6, rand_bits(32)};
        add_step("bypass_fwd1", make_inst(5'd6, 5'd7, 16'h0), c, iw, '{1'b1, 5'd9, rand_bits(32)});
        iw = '{1'b1, 5'd7, rand_bits(32)};
        add_step("bypass_fwd2", make_inst(5'd6, 5'd7, 16'h0), c, iw, '{1'b1, 5'd9, rand_bits(32)});
        for (int k = 0; k < 48; k++) begin
            w        = rand_bits(32);
            c        = dec_ctrl_t'(8'(rand_bits(8)));
            iw.write = 1'(rand_bits(1));
            iw.sel   = (rand_bits(1) != 0) ? w[25:21] : reg_idx_t'(rand_bits(5));
            iw.data  = rand_bits(32);
            fw.write = 1'(rand_bits(1));
            fw.sel   = (rand_bits(1) != 0) ? w[20:16] : reg_idx_t'(rand_bits(5));
            fw.data  = rand_bits(32);
            add_step("random", w, c, iw, fw);
        end
    endtask

    ////////////////////
    // Checks and waits
    ////////////////////

    task automatic check_eq(string name, reg_word_t expected, reg_word_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic wait_fall(string what);
        int n;
        n = 0;
        while (clk !== 1'b1 && n < WAIT_LIMIT) begin
            #0.5;
            n++;
        end
        while (clk !== 1'b0 && n < WAIT_LIMIT) begin
            #0.5;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("test failed");
            $fatal(1, "clock stopped while waiting for %s", what);
        end
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (reset !== 1'b0 && n < WAIT_LIMIT) begin
            #0.5;
            n++;
        end
        if (reset !== 1'b0) begin
            $display("test failed");
            $fatal(1, "reset never released");
        end
    endtask

    initial begin
        string tag;
        inst   = '0;
        ctrl   = '0;
        int_wr = '0;
        fp_wr  = '0;
        lfsr   = 32'hbec7;
        for (int r = 0; r < NUM_REGS; r++) begin
            int_model[r] = '0;
            fp_model[r]  = '0;
        end
        build_table();
        // Poll off the clock edges
        #0.25;
        wait_reset_done();
        foreach (steps[i]) begin
            wait_fall(steps[i].name);
            inst   = steps[i].inst;
            ctrl   = steps[i].ctrl;
            int_wr = steps[i].int_wr;
            fp_wr  = steps[i].fp_wr;
            #9;
            tag = $sformatf("%s #%0d", steps[i].name, i);
            check_eq({tag, " reg1"}, steps[i].exp.reg1, result.reg1);
            check_eq({tag, " reg2"}, steps[i].exp.reg2, result.reg2);
            check_eq({tag, " fp_reg1"}, steps[i].exp.fp_reg1, result.fp_reg1);
            check_eq({tag, " fp_reg2"}, steps[i].exp.fp_reg2, result.fp_reg2);
            check_eq({tag, " imm"}, steps[i].exp.imm, result.imm);
            check_eq({tag, " ofs"}, steps[i].exp.ofs, result.ofs);
            check_eq({tag, " decode_err"}, {31'b0, steps[i].exp.decode_err},
                     {31'b0, result.decode_err});
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/decode_pkg.sv
rtl/reg_file.sv
rtl/bank_port_steer.sv
rtl/operand_mux.sv
rtl/decode_stage.sv
dv/tb_clock.sv
dv/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decode_tb -Mdir obj_dir -o decode_sim -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0
